//--- logic/kiwi_pkg.sv
/*
 * shared definitions for the receive front end
 * widths, fifo sizing, apb request/response structs,
 * register map, ctrl bit positions, id/version constants
 */

`default_nettype none

package kiwi_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizing
    //////////////////////////////////////////////////////////////////////

    localparam int adc_bits   = 14;                 // adc sample width
    localparam int fifo_depth = 8;                  // sample fifo entries
    localparam int fifo_aw    = $clog2(fifo_depth); // 3

    // one adc sample plus its overflow flag, 15 bits
    typedef struct packed {
        logic signed [adc_bits-1:0] data;
        logic                       ovfl;
    } adc_sample_t;

    //////////////////////////////////////////////////////////////////////
    // host bus
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [15:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [15:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [7:0] reg_ctrl   = 8'h00; // r/w
    localparam logic [7:0] reg_status = 8'h04; // r, w1 on bit 15 clears ovfl
    localparam logic [7:0] reg_sample = 8'h08; // r, pops fifo
    localparam logic [7:0] reg_cnt_lo = 8'h0c; // r, latches high half
    localparam logic [7:0] reg_cnt_hi = 8'h10; // r, latched value

    // ctrl bits routed to pins, rest is plain storage
    localparam int ctrl_osc_en    = 0;
    localparam int ctrl_sten      = 1;
    localparam int ctrl_eeprom_wp = 2;
    localparam int ctrl_cmd_ready = 3;

    localparam logic [3:0] fpga_id  = 4'h1;
    localparam logic [3:0] fpga_ver = 4'h2;

endpackage

`default_nettype wire

//--- logic/adc_capture.sv
/*
 * adc capture stage (producer)
 * pin register, push valid, 32-bit sample counter, drop flag
 */

`timescale 1ns/1ps
`default_nettype none

module adc_capture (
    input  logic                          cpu_clk,
    input  logic                          rx_orst,
    input  logic signed [kiwi_pkg::adc_bits-1:0] adc_data,
    input  logic                          adc_ovfl,
    input  logic                          osc_en,
    input  logic                          full,
    output logic                          push_valid,
    output logic                          drop,
    output kiwi_pkg::adc_sample_t         push_data,
    output logic [31:0]                   adc_count
);

    logic take_q; // sample in push_data was taken with osc on

    //////////////////////////////////////////////////////////////////////
    // pin register
    //////////////////////////////////////////////////////////////////////

    // pins into the sample struct every cycle
    always_ff @(posedge cpu_clk)
    begin
        push_data.data <= adc_data;
        push_data.ovfl <= adc_ovfl;
    end

    // qualifier follows the oscillator enable by one edge
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            take_q <= 1'b0;
        else
            take_q <= osc_en;
    end

    assign push_valid = take_q;

    //////////////////////////////////////////////////////////////////////
    // sample counter
    //////////////////////////////////////////////////////////////////////

    // counts every enabled sample, dropped ones too
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            adc_count <= 32'd0;
        else if (take_q)
            adc_count <= adc_count + 32'd1;
    end

    // fifo full at push time, sample lost
    assign drop = take_q & full;

endmodule

`default_nettype wire

//--- logic/sample_fifo.sv
/*
 * first-word-fall-through sample fifo (buffer)
 * circular store, rd/wr pointers, entry count and level
 */

`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    input  logic                  push,
    input  kiwi_pkg::adc_sample_t push_data,
    input  logic                  pop,
    output kiwi_pkg::adc_sample_t head,
    output logic                  empty,
    output logic                  full,
    output logic [3:0]            level
);

    kiwi_pkg::adc_sample_t             mem [kiwi_pkg::fifo_depth]; // sample store
    logic [kiwi_pkg::fifo_aw-1:0]      wr_ptr;
    logic [kiwi_pkg::fifo_aw-1:0]      rd_ptr;
    logic [kiwi_pkg::fifo_aw:0]        count;  // 0..depth
    logic                              do_push;
    logic                              do_pop;

    // illegal ops just fall away
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assign head = mem[rd_ptr]; // oldest entry, no pop needed

    //////////////////////////////////////////////////////////////////////
    // pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // power of two depth, wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or push and pop together
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == (kiwi_pkg::fifo_aw + 1)'(kiwi_pkg::fifo_depth));
    assign level = count;

endmodule

`default_nettype wire

//--- logic/host_regs.sv
/*
 * host register block (consumer), apb slave
 * ctrl register, status word with sticky overflow,
 * fifo head pop, split counter read, error response
 */

`timescale 1ns/1ps
`default_nettype none

module host_regs (
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    input  kiwi_pkg::apb_req_t    apb_req,
    input  kiwi_pkg::adc_sample_t head,
    input  logic                  empty,
    input  logic [3:0]            level,
    input  logic                  drop,
    input  logic [31:0]           adc_count,
    output kiwi_pkg::apb_rsp_t    apb_rsp,
    output logic [15:0]           ctrl,
    output logic                  pop
);

    logic        access;      // apb access phase
    logic        rd;
    logic        wr;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_sample;
    logic        hit_lo;
    logic        hit_hi;
    logic        addr_ok;
    logic        ro_write;
    logic        ovfl_clr;
    logic        ovfl_q;      // sticky rx overflow
    logic [15:0] cnt_hi_q;    // upper counter half, latched on lo read
    logic [15:0] status;
    logic [15:0] rdata;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign access = apb_req.psel & apb_req.penable;
    assign rd     = access & ~apb_req.pwrite;
    assign wr     = access & apb_req.pwrite;

    assign hit_ctrl   = (apb_req.paddr == kiwi_pkg::reg_ctrl);
    assign hit_status = (apb_req.paddr == kiwi_pkg::reg_status);
    assign hit_sample = (apb_req.paddr == kiwi_pkg::reg_sample);
    assign hit_lo     = (apb_req.paddr == kiwi_pkg::reg_cnt_lo);
    assign hit_hi     = (apb_req.paddr == kiwi_pkg::reg_cnt_hi);

    assign addr_ok  = hit_ctrl | hit_status | hit_sample | hit_lo | hit_hi;
    assign ro_write = apb_req.pwrite & (hit_sample | hit_lo | hit_hi);

    assign ovfl_clr = wr & hit_status & apb_req.pwdata[15];
    assign pop      = rd & hit_sample & ~empty; // empty read pops nothing

    // ovfl, pad, version, level, id
    assign status = {ovfl_q, 3'b000, kiwi_pkg::fpga_ver, level, kiwi_pkg::fpga_id};

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctrl     <= 16'h0000;
            ovfl_q   <= 1'b0;
            cnt_hi_q <= 16'h0000;
        end
        else
        begin
            if (wr & hit_ctrl)
                ctrl <= apb_req.pwdata;
            ovfl_q <= (ovfl_q & ~ovfl_clr) | drop;  // new drop beats the clear
            if (rd & hit_lo)
                cnt_hi_q <= adc_count[31:16];       // keeps the pair coherent
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux and response
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rdata = 16'h0000;
        if (hit_ctrl)
            rdata = ctrl;
        else if (hit_status)
            rdata = status;
        else if (hit_sample && !empty)
            rdata = {head.ovfl, 1'b0, head.data}; // ovfl in bit 15
        else if (hit_lo)
            rdata = adc_count[15:0];
        else if (hit_hi)
            rdata = cnt_hi_q;
    end

    always_comb
    begin
        apb_rsp.prdata  = rd ? rdata : 16'h0000;
        apb_rsp.pready  = 1'b1;                          // no wait states
        apb_rsp.pslverr = access & (~addr_ok | ro_write);
    end

endmodule

`default_nettype wire

//--- logic/rx_frontend.sv
/*
 * receive front end top level
 * capture -> sample fifo -> host registers, ctrl pin mapping
 */

`timescale 1ns/1ps
`default_nettype none

module rx_frontend (
    input  logic                                 cpu_clk,
    input  logic                                 rx_orst,
    input  kiwi_pkg::apb_req_t                   apb_req,
    input  logic signed [kiwi_pkg::adc_bits-1:0] adc_data,
    input  logic                                 adc_ovfl,
    output kiwi_pkg::apb_rsp_t                   apb_rsp,
    output logic                                 adc_clken,
    output logic                                 adc_stenl,
    output logic                                 ewp,
    output logic                                 cmd_ready
);

    logic                  push_valid;
    logic                  drop;
    kiwi_pkg::adc_sample_t push_data;
    logic [31:0]           adc_count;
    kiwi_pkg::adc_sample_t head;
    logic                  empty;
    logic                  full;
    logic [3:0]            level;
    logic                  pop;
    logic [15:0]           ctrl;

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    adc_capture adc_capture_inst (
        .cpu_clk    (cpu_clk),
        .rx_orst    (rx_orst),
        .adc_data   (adc_data),
        .adc_ovfl   (adc_ovfl),
        .osc_en     (ctrl[kiwi_pkg::ctrl_osc_en]),
        .full       (full),
        .push_valid (push_valid),
        .drop       (drop),
        .push_data  (push_data),
        .adc_count  (adc_count)
    );

    sample_fifo sample_fifo_inst (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .push      (push_valid),  // fifo ignores it when full
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .level     (level)
    );

    host_regs host_regs_inst (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .apb_req   (apb_req),
        .head      (head),
        .empty     (empty),
        .level     (level),
        .drop      (drop),
        .adc_count (adc_count),
        .apb_rsp   (apb_rsp),
        .ctrl      (ctrl),
        .pop       (pop)
    );

    // control pins straight from ctrl
    assign adc_clken = ctrl[kiwi_pkg::ctrl_osc_en];
    assign adc_stenl = ~ctrl[kiwi_pkg::ctrl_sten];  // self-test, active low
    assign ewp       = ctrl[kiwi_pkg::ctrl_eeprom_wp];
    assign cmd_ready = ctrl[kiwi_pkg::ctrl_cmd_ready];

endmodule

`default_nettype wire

//--- test/rx_frontend_props.sv
/*
 * bound checks on the host register block
 * apb phase order, bad access side effects, fifo level seen at its ports
 */

`timescale 1ns/1ps
`default_nettype none

module rx_frontend_props (
    input logic               cpu_clk,
    input logic               rx_orst,
    input kiwi_pkg::apb_req_t apb_req,
    input kiwi_pkg::apb_rsp_t apb_rsp,
    input logic [15:0]        ctrl,
    input logic               pop,
    input logic [3:0]         level
);

    logic access;
    logic setup;
    int   fail_count = 0; // failed assertions so far

    assign access = apb_req.psel & apb_req.penable; // access phase
    assign setup  = apb_req.psel & ~apb_req.penable;

    access_after_setup: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        access |-> $past(setup))
        else
        begin
            $error("apb access without a setup cycle before it");
            fail_count++;
        end

    bad_access_keeps_ctrl: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        apb_rsp.pslverr |=> $stable(ctrl))
        else
        begin
            $error("ctrl changed by an access that got pslverr");
            fail_count++;
        end

    pop_lowers_level: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        pop |=> level <= $past(level))
        else
        begin
            $error("fifo level rose across a pop");
            fail_count++;
        end

    level_in_range: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        level <= 4'(kiwi_pkg::fifo_depth))
        else
        begin
            $error("fifo level above depth");
            fail_count++;
        end

    // one push or one pop per edge at most
    level_steps_by_one: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        level == $past(level) || level == $past(level) + 4'd1 ||
        level + 4'd1 == $past(level))
        else
        begin
            $error("fifo level jumped by more than one");
            fail_count++;
        end

endmodule

// fifo pop and level pass through host_regs ports
bind host_regs rx_frontend_props rx_frontend_props_inst (
    .cpu_clk (cpu_clk),
    .rx_orst (rx_orst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .ctrl    (ctrl),
    .pop     (pop),
    .level   (level)
);

`default_nettype wire

//--- test/rx_frontend_tb.sv
/*
 * testbench for the receive front end
 * command file player: apb writes and reads, adc pins, idles, pin checks
 * error counters and closing verdict
 */

`timescale 1ns/1ps
`default_nettype none

module rx_frontend_tb;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int wait_limit   = 50;    // cycles allowed for pready

    logic                                 cpu_clk;
    logic                                 rx_orst;
    kiwi_pkg::apb_req_t                   apb_req;
    kiwi_pkg::apb_rsp_t                   apb_rsp;
    logic signed [kiwi_pkg::adc_bits-1:0] adc_data;
    logic                                 adc_ovfl;
    logic                                 adc_clken;
    logic                                 adc_stenl;
    logic                                 ewp;
    logic                                 cmd_ready;

    int               value_errors;     // wrong data, flag or pin
    int               timeouts;
    int               file_errors;      // unreadable or bad stimulus lines
    int               assert_errors;    // bound property failures
    int               checks;
    int               fd;
    int               code;
    int               i;
    logic             done;
    logic [7:0]       cmd;
    logic [31:0]      arg_a;
    logic [31:0]      arg_b;
    logic [31:0]      arg_c;
    logic [8*128-1:0] skip_line;        // rest of a comment line
    logic [15:0]      rd_data;
    logic             rd_err;

    rx_frontend rx_frontend_inst (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .apb_req   (apb_req),
        .adc_data  (adc_data),
        .adc_ovfl  (adc_ovfl),
        .apb_rsp   (apb_rsp),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .ewp       (ewp),
        .cmd_ready (cmd_ready)
    );

    initial
    begin
        cpu_clk = 1'b0;
        forever #(clk_period / 2) cpu_clk = ~cpu_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // apb transfer, called on a falling edge, returns on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [15:0] wdata,
                                output logic [15:0] rdata, output logic err);
        int cycles;
        begin
            apb_req.psel    = 1'b1;     // setup phase
            apb_req.penable = 1'b0;
            apb_req.pwrite  = write;
            apb_req.paddr   = addr;
            apb_req.pwdata  = wdata;
            @(negedge cpu_clk);
            apb_req.penable = 1'b1;     // access phase
            #(clk_period / 4);          // settle, well ahead of the rising edge
            cycles = 0;
            while (!apb_rsp.pready && cycles < wait_limit)
            begin
                @(negedge cpu_clk);
                #(clk_period / 4);
                cycles++;
            end
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            if (!apb_rsp.pready)
            begin
                $display("APB access to %h never saw pready in %0d cycles", addr, wait_limit);
                timeouts++;
            end
            @(negedge cpu_clk);         // access ends on the edge before
            apb_req = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // command player
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rx_orst       = 1'b1;
        apb_req       = '0;
        adc_data      = '0;
        adc_ovfl      = 1'b0;
        value_errors  = 0;
        timeouts      = 0;
        file_errors   = 0;
        assert_errors = 0;
        checks        = 0;
        done          = 1'b0;
        repeat (reset_cycles) @(negedge cpu_clk);
        rx_orst = 1'b0;

        fd = $fopen("test/rx_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file test/rx_stimulus.txt");
            file_errors++;
            done = 1'b1;
        end
        while (!done)
        begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1)
                done = 1'b1;                        // end of file
            else
            begin
                case (cmd)
                    "#": code = $fgets(skip_line, fd);
                    "W", "R":
                    begin
                        code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                        if (code != 3)
                        begin
                            $display("Stimulus line for %c has the wrong fields", cmd);
                            file_errors++;
                            done = 1'b1;
                        end
                        else
                        begin
                            apb_transfer(cmd == "W", arg_a[7:0], arg_b[15:0], rd_data, rd_err);
                            checks++;
                            if (cmd == "R" && rd_data !== arg_b[15:0])
                            begin
                                $display("Error at %0t: read %h gave %h, expected %h",
                                         $time, arg_a[7:0], rd_data, arg_b[15:0]);
                                value_errors++;
                            end
                            if (rd_err !== arg_c[0])
                            begin
                                $display("Error at %0t: %c %h pslverr %b, expected %b",
                                         $time, cmd, arg_a[7:0], rd_err, arg_c[0]);
                                value_errors++;
                            end
                        end
                    end
                    "S":
                    begin
                        code = $fscanf(fd, "%h %h", arg_a, arg_b);
                        adc_data = arg_a[kiwi_pkg::adc_bits-1:0];
                        adc_ovfl = arg_b[0];
                        @(negedge cpu_clk);         // one sample period
                        if (code != 2)
                        begin
                            $display("Stimulus line for S has the wrong fields");
                            file_errors++;
                            done = 1'b1;
                        end
                    end
                    "I":
                    begin
                        code = $fscanf(fd, "%h", arg_a);
                        if (code != 1)
                        begin
                            $display("Stimulus line for I has the wrong fields");
                            file_errors++;
                            done = 1'b1;
                        end
                        else
                            for (i = 0; i < int'(arg_a[15:0]); i++)
                                @(negedge cpu_clk);
                    end
                    "P":
                    begin
                        code = $fscanf(fd, "%h", arg_a);
                        if (code != 1)
                        begin
                            $display("Stimulus line for P has the wrong fields");
                            file_errors++;
                            done = 1'b1;
                        end
                        else
                        begin
                            checks++;
                            // mask order cmd_ready, ewp, adc_stenl, adc_clken
                            if ({cmd_ready, ewp, adc_stenl, adc_clken} !== arg_a[3:0])
                            begin
                                $display("Error at %0t: pins %b, expected %b", $time,
                                         {cmd_ready, ewp, adc_stenl, adc_clken}, arg_a[3:0]);
                                value_errors++;
                            end
                        end
                    end
                    default:
                    begin
                        $display("Unknown command %c in the stimulus file", cmd);
                        file_errors++;
                        done = 1'b1;
                    end
                endcase
            end
            if (timeouts != 0)
                done = 1'b1;                        // stop after a hung handshake
        end
        if (fd != 0)
            $fclose(fd);

        assert_errors = rx_frontend_inst.host_regs_inst.rx_frontend_props_inst.fail_count;
        $display("checks %0d, value errs %0d, timeouts %0d, file errs %0d, assert errs %0d",
                 checks, value_errors, timeouts, file_errors, assert_errors);
        if (value_errors == 0 && timeouts == 0 && file_errors == 0 && assert_errors == 0
            && checks > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rx_stimulus.txt
# W addr data errflag | R addr expected errflag | S data ovfl | I cycles | P pinmask
# all hex; pinmask bits 3..0 = cmd_ready ewp adc_stenl adc_clken
R 04 0201 0
P 2
W 00 5a0e 0
R 00 5a0e 0
P c
# unmapped read and write to sample, nothing may change
R 20 0000 1
W 08 1234 1
R 00 5a0e 0
R 04 0201 0
# three driven values, last one held through the two-cycle disable write
W 00 0001 0
P 3
S 0123 0
S 3f00 1
S 1555 0
W 00 0000 0
R 04 0251 0
R 08 0123 0
R 08 bf00 0
R 08 1555 0
R 08 1555 0
R 08 1555 0
R 08 0000 0
R 04 0201 0
# twelve enabled samples, four of them dropped
W 00 0001 0
S 0001 0
S 0002 1
S 2000 0
S 1fff 1
S 0aaa 0
S 3555 1
I 4
W 00 0000 0
R 04 8281 0
R 08 0001 0
R 08 8002 0
R 08 2000 0
R 08 9fff 0
R 08 0aaa 0
R 08 b555 0
R 08 b555 0
R 08 b555 0
R 04 8201 0
W 04 8000 0
R 04 0201 0
# 5 + 12 enabled samples
R 0c 0011 0
R 10 0000 0
P 2

//--- src.f
logic/kiwi_pkg.sv
logic/adc_capture.sv
logic/sample_fifo.sv
logic/host_regs.sv
logic/rx_frontend.sv
test/rx_frontend_props.sv
test/rx_frontend_tb.sv

//--- Makefile
# Verilator build and run for the receive front end

VERILATOR ?= verilator
TOP       ?= rx_frontend_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
